/* source/fp_types_pkg.sv */
// binary32 field types
// format constants for the adder core and its driver

package fp_types_pkg;

  // ----------------------------
  // field types
  // ----------------------------
  typedef logic [31:0] fp32_t;    // sign, exponent, fraction
  typedef logic [7:0]  fp_exp_t;  // biased exponent
  typedef logic [22:0] fp_man_t;  // stored fraction, hidden bit not included

  // ----------------------------
  // format constants
  // ----------------------------
  localparam int FP_BIAS = 127;

  // all ones exponent marks infinity and nan
  localparam fp_exp_t FP_EXP_INF = 8'hFF;

  localparam fp32_t FP_QNAN = 32'h7FC0_0000;  // canonical quiet nan

endpackage

/* source/fp_add_regs_pkg.sv */
// host register map of the fp add unit
// address type, register addresses, status bit positions

package fp_add_regs_pkg;

  typedef logic [2:0] reg_addr_t;

  // register addresses
  localparam reg_addr_t ADDR_OPA    = 3'd0;  // rw
  localparam reg_addr_t ADDR_OPB    = 3'd1;  // rw
  localparam reg_addr_t ADDR_CTRL   = 3'd2;  // wo, bit 0 is go
  localparam reg_addr_t ADDR_STATUS = 3'd3;  // ro
  localparam reg_addr_t ADDR_RESULT = 3'd4;  // ro

  // status bits
  localparam int STAT_BUSY_BIT = 0;
  localparam int STAT_DONE_BIT = 1;

endpackage

/* source/fp_stream_if.sv */
// operand and result channels between driver and adder core
// strobe/acknowledge transfers, one word per transfer

interface fp_stream_if import fp_types_pkg::*; ();

  // operand a
  fp32_t a;
  logic  a_stb;
  logic  a_ack;

  // operand b
  fp32_t b;
  logic  b_stb;
  logic  b_ack;

  // sum
  fp32_t z;
  logic  z_stb;
  logic  z_ack;

  modport src (output a, a_stb, b, b_stb, z_ack,
               input  a_ack, b_ack, z, z_stb);

  modport snk (output a_ack, b_ack, z, z_stb,
               input  a, a_stb, b, b_stb, z_ack);

endinterface

/* source/fp_req_if.sv */
// request and status link between register block and driver

interface fp_req_if import fp_types_pkg::*; ();

  logic  start;  // one cycle pulse
  fp32_t a;
  fp32_t b;

  logic  busy;
  logic  done;   // sticky until next accepted start
  fp32_t z;

  modport regs (output start, a, b,
                input  busy, done, z);

  modport drv  (output busy, done, z,
                input  start, a, b);

endinterface

/* source/fp_adder.sv */
// serial binary32 adder core
// strobe/acknowledge operand and result channels
// round to nearest even, subnormals supported, one bit shifted per cycle

module fp_adder import fp_types_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  fp_stream_if.snk stream
);

  typedef enum logic [3:0] {
    GET_A, GET_B, UNPACK, ALIGN, ADD, NORM, ROUND, PACK, PUT_Z
  } add_state_t;

  add_state_t state;

  fp32_t       a_in, b_in;      // raw operands
  logic        a_s, b_s, z_s;
  logic [9:0]  a_e, b_e, z_e;   // unbiased by nothing, subnormals use 1
  logic [26:0] a_m, b_m;        // hidden bit, fraction, guard, round, sticky
  logic [27:0] sum;             // carry on top
  logic [23:0] man;

  // ----------------------------
  // field decode and specials
  // ----------------------------
  fp_exp_t a_ef, b_ef;
  fp_man_t a_mf, b_mf;
  logic    a_nan, b_nan, a_inf, b_inf, a_zero, b_zero;
  logic    special;
  fp32_t   special_z;

  assign a_ef = a_in[30:23];
  assign b_ef = b_in[30:23];
  assign a_mf = a_in[22:0];
  assign b_mf = b_in[22:0];

  assign a_nan  = (a_ef == FP_EXP_INF) && (a_mf != '0);
  assign b_nan  = (b_ef == FP_EXP_INF) && (b_mf != '0);
  assign a_inf  = (a_ef == FP_EXP_INF) && (a_mf == '0);
  assign b_inf  = (b_ef == FP_EXP_INF) && (b_mf == '0);
  assign a_zero = (a_in[30:0] == '0);
  assign b_zero = (b_in[30:0] == '0);

  always_comb begin
    special   = 1'b1;
    special_z = FP_QNAN;
    if (a_nan || b_nan || (a_inf && b_inf && (a_in[31] != b_in[31]))) begin
      special_z = FP_QNAN;
    end else if (a_inf) begin
      special_z = a_in;
    end else if (b_inf) begin
      special_z = b_in;
    end else if (a_zero && b_zero) begin
      special_z = {a_in[31] & b_in[31], 31'd0};  // +0 unless both negative
    end else if (a_zero) begin
      special_z = b_in;
    end else if (b_zero) begin
      special_z = a_in;
    end else begin
      special = 1'b0;
    end
  end

  // ----------------------------
  // rounding
  // ----------------------------
  logic        round_up;
  logic [24:0] man_rnd;

  // guard and (lsb or round or sticky)
  assign round_up = sum[2] & (sum[3] | sum[1] | sum[0]);
  assign man_rnd  = {1'b0, sum[26:3]} + {24'd0, round_up};

  // one step right, lost bits fold into sticky
  function automatic logic [26:0] shr_sticky(input logic [26:0] m);
    return {1'b0, m[26:2], m[1] | m[0]};
  endfunction

  // ----------------------------
  // main FSM
  // ----------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= GET_A;
      stream.a_ack <= 1'b0;
      stream.b_ack <= 1'b0;
      stream.z_stb <= 1'b0;
    end else begin
      case (state)
        GET_A: begin
          if (stream.a_ack && stream.a_stb) begin
            a_in         <= stream.a;
            stream.a_ack <= 1'b0;
            state        <= GET_B;
          end else begin
            stream.a_ack <= 1'b1;
          end
        end

        GET_B: begin
          if (stream.b_ack && stream.b_stb) begin
            b_in         <= stream.b;
            stream.b_ack <= 1'b0;
            state        <= UNPACK;
          end else begin
            stream.b_ack <= 1'b1;
          end
        end

        UNPACK: begin
          a_s <= a_in[31];
          b_s <= b_in[31];
          a_e <= (a_ef == '0) ? 10'd1 : {2'b00, a_ef};
          b_e <= (b_ef == '0) ? 10'd1 : {2'b00, b_ef};
          a_m <= {a_ef != '0, a_mf, 3'b000};
          b_m <= {b_ef != '0, b_mf, 3'b000};
          if (special) begin
            stream.z     <= special_z;
            stream.z_stb <= 1'b1;
            state        <= PUT_Z;
          end else begin
            state <= ALIGN;
          end
        end

        ALIGN: begin
          if (a_e > b_e) begin
            if (b_m[26:1] == '0) b_e <= a_e;  // only sticky left
            else begin
              b_m <= shr_sticky(b_m);
              b_e <= b_e + 10'd1;
            end
          end else if (b_e > a_e) begin
            if (a_m[26:1] == '0) a_e <= b_e;
            else begin
              a_m <= shr_sticky(a_m);
              a_e <= a_e + 10'd1;
            end
          end else begin
            state <= ADD;
          end
        end

        ADD: begin
          z_e <= a_e;
          if (a_s == b_s) begin
            sum <= {1'b0, a_m} + {1'b0, b_m};
            z_s <= a_s;
          end else if (a_m >= b_m) begin
            sum <= {1'b0, a_m - b_m};
            z_s <= (a_m == b_m) ? 1'b0 : a_s;  // exact cancel gives +0
          end else begin
            sum <= {1'b0, b_m - a_m};
            z_s <= b_s;
          end
          state <= NORM;
        end

        NORM: begin
          if (sum[27]) begin
            sum <= {1'b0, sum[27:2], sum[1] | sum[0]};
            z_e <= z_e + 10'd1;
          end else if (!sum[26] && z_e > 10'd1 && sum != '0) begin
            sum <= {sum[26:0], 1'b0};  // stops at subnormal boundary
            z_e <= z_e - 10'd1;
          end else begin
            state <= ROUND;
          end
        end

        ROUND: begin
          if (man_rnd[24]) begin
            man <= man_rnd[24:1];  // mantissa overflow
            z_e <= z_e + 10'd1;
          end else begin
            man <= man_rnd[23:0];
          end
          state <= PACK;
        end

        PACK: begin
          if (z_e >= 10'd255) stream.z <= {z_s, FP_EXP_INF, 23'd0};
          else stream.z <= {z_s, man[23] ? z_e[7:0] : 8'd0, man[22:0]};
          stream.z_stb <= 1'b1;
          state        <= PUT_Z;
        end

        PUT_Z: begin
          if (stream.z_stb && stream.z_ack) begin
            stream.z_stb <= 1'b0;
            state        <= GET_A;
          end
        end

        default: state <= GET_A;
      endcase
    end
  end

endmodule

/* source/fp_add_driver.sv */
// request sequencer for the serial adder core
// latches operands, strobes a then b, waits for the sum

module fp_add_driver (
  input  logic     clk,
  input  logic     rst,
  fp_req_if.drv    req,
  fp_stream_if.src stream
);

  typedef enum logic [1:0] {
    IDLE,
    SEND_A,
    SEND_B,
    WAIT_Z
  } drv_state_t;

  drv_state_t state;
  logic       accept;

  assign accept   = (state == IDLE) && req.start;  // start while busy is dropped
  assign req.busy = (state != IDLE);

  // ----------------------------
  // operand latch
  // ----------------------------
  // held until the core takes them, host may rewrite OPA/OPB meanwhile
  always_ff @(posedge clk) begin
    if (accept) begin
      stream.a <= req.a;
      stream.b <= req.b;
    end
  end

  // ----------------------------
  // sequencing FSM
  // ----------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= IDLE;
      stream.a_stb  <= 1'b0;
      stream.b_stb  <= 1'b0;
      stream.z_ack  <= 1'b0;
      req.done      <= 1'b0;
      req.z         <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (accept) begin
            req.done     <= 1'b0;
            stream.a_stb <= 1'b1;
            state        <= SEND_A;
          end
        end

        SEND_A: begin
          if (stream.a_stb && stream.a_ack) begin
            stream.a_stb <= 1'b0;
            stream.b_stb <= 1'b1;
            state        <= SEND_B;
          end
        end

        SEND_B: begin
          if (stream.b_stb && stream.b_ack) begin
            stream.b_stb <= 1'b0;
            stream.z_ack <= 1'b1;  // ready for the sum
            state        <= WAIT_Z;
          end
        end

        WAIT_Z: begin
          if (stream.z_stb && stream.z_ack) begin
            req.z        <= stream.z;
            req.done     <= 1'b1;  // sticky
            stream.z_ack <= 1'b0;
            state        <= IDLE;
          end
        end

        default: state <= IDLE;
      endcase
    end
  end

endmodule

/* source/fp_add_regs.sv */
// host register block of the fp add unit
// operand registers, go pulse, status and result readback

module fp_add_regs import fp_add_regs_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        wr_en,
  input  logic        rd_en,
  input  reg_addr_t   addr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata,
  fp_req_if.regs      req
);

  logic [31:0] status;

  always_comb begin
    status                = '0;
    status[STAT_BUSY_BIT] = req.busy;
    status[STAT_DONE_BIT] = req.done;
  end

  // ----------------------------
  // write side
  // ----------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      req.a     <= '0;
      req.b     <= '0;
      req.start <= 1'b0;
    end else begin
      req.start <= wr_en && (addr == ADDR_CTRL) && wdata[0];  // high for one cycle
      if (wr_en && (addr == ADDR_OPA)) req.a <= wdata;
      if (wr_en && (addr == ADDR_OPB)) req.b <= wdata;
    end
  end

  // ----------------------------
  // read side
  // ----------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      rdata <= '0;
    end else if (rd_en) begin
      case (addr)
        ADDR_OPA:    rdata <= req.a;
        ADDR_OPB:    rdata <= req.b;
        ADDR_STATUS: rdata <= status;
        ADDR_RESULT: rdata <= req.z;
        default:     rdata <= '0;  // ctrl and unmapped
      endcase
    end
  end

endmodule

/* source/fp_add_unit.sv */
// fp add unit top level
// register block, driver and serial adder core

module fp_add_unit import fp_add_regs_pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        wr_en,
  input  logic        rd_en,
  input  reg_addr_t   addr,
  input  logic [31:0] wdata,
  output logic [31:0] rdata
);

  fp_req_if    req_if ();
  fp_stream_if stream_if ();

  // ----------------------------
  // host side
  // ----------------------------
  fp_add_regs u_regs (
    .clk   (clk),
    .rst   (rst),
    .wr_en (wr_en),
    .rd_en (rd_en),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata),
    .req   (req_if.regs)
  );

  // ----------------------------
  // sequencing and arithmetic
  // ----------------------------
  fp_add_driver u_driver (
    .clk    (clk),
    .rst    (rst),
    .req    (req_if.drv),
    .stream (stream_if.src)
  );

  fp_adder u_adder (
    .clk    (clk),
    .rst    (rst),
    .stream (stream_if.snk)
  );

endmodule

/* verif/fp_add_unit_checker.sv */
// concurrent checks on the driver handshakes and status
// bound into fp_add_driver

module fp_add_unit_checker import fp_types_pkg::*; (
  input logic  clk,
  input logic  rst,
  input logic  start,
  input logic  busy,
  input logic  done,
  input fp32_t a,
  input logic  a_stb,
  input logic  a_ack,
  input fp32_t b,
  input logic  b_stb,
  input logic  b_ack,
  input logic  z_ack
);

  timeunit 1ns;
  timeprecision 1ps;

  busy_done_excl: assert property (@(posedge clk) disable iff (rst) !(busy && done))
    else $error("busy and done high together");

  // strobe and data hold until the acknowledge
  a_stb_hold: assert property (@(posedge clk) disable iff (rst)
    a_stb && !a_ack |=> a_stb && $stable(a))
    else $error("a strobe dropped or a changed before its acknowledge");

  b_stb_hold: assert property (@(posedge clk) disable iff (rst)
    b_stb && !b_ack |=> b_stb && $stable(b))
    else $error("b strobe dropped or b changed before its acknowledge");

  z_ack_busy: assert property (@(posedge clk) disable iff (rst) z_ack |-> busy)
    else $error("z acknowledge high while idle");

  start_to_busy: assert property (@(posedge clk) disable iff (rst) start && !busy |=> busy)
    else $error("start while idle did not raise busy");

endmodule

bind fp_add_driver fp_add_unit_checker u_checker (
  .clk   (clk),
  .rst   (rst),
  .start (req.start),
  .busy  (req.busy),
  .done  (req.done),
  .a     (stream.a),
  .a_stb (stream.a_stb),
  .a_ack (stream.a_ack),
  .b     (stream.b),
  .b_stb (stream.b_stb),
  .b_ack (stream.b_ack),
  .z_ack (stream.z_ack)
);

/* verif/fp_add_unit_tb.sv */
// testbench for the fp add unit
// lcg operand stimulus, binary32 reference model, register-level checks, watchdog

module fp_add_unit_tb import fp_types_pkg::*, fp_add_regs_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int NUM_RANDOM = 300;
  localparam int NUM_OPS    = NUM_RANDOM + 40;  // random plus directed

  logic        clk = 1'b0;
  logic        rst;
  logic        wr_en;
  logic        rd_en;
  reg_addr_t   addr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic [31:0] seed;

  fp_add_unit u_dut (
    .clk   (clk),
    .rst   (rst),
    .wr_en (wr_en),
    .rd_en (rd_en),
    .addr  (addr),
    .wdata (wdata),
    .rdata (rdata)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // ----------------------------
  // reference model
  // ----------------------------
  // exact sum as integer significand times 2^(emin - 150), then one rounding
  function automatic fp32_t ref_sum(input fp32_t a, input fp32_t b);
    logic [279:0] ma, mb, mag, rem, low_mask;
    logic [24:0]  kept;
    logic         sz;
    int           ea, eb, emin, msb, e, s;
    ea = (a[30:23] == 8'd0) ? 1 : int'(a[30:23]);
    eb = (b[30:23] == 8'd0) ? 1 : int'(b[30:23]);
    if ((a[30:23] == 8'hFF && a[22:0] != '0) || (b[30:23] == 8'hFF && b[22:0] != '0))
      return FP_QNAN;
    if (a[30:0] == 31'h7F80_0000 && b[30:0] == 31'h7F80_0000)
      return (a[31] == b[31]) ? a : FP_QNAN;
    if (a[30:23] == 8'hFF)
      return a;
    if (b[30:23] == 8'hFF)
      return b;
    if (a[30:0] == '0 && b[30:0] == '0)
      return (a[31] && b[31]) ? 32'h8000_0000 : 32'h0000_0000;  // -0 only when both negative
    emin = (ea < eb) ? ea : eb;
    ma = {256'd0, a[30:23] != 8'd0, a[22:0]} << (ea - emin);
    mb = {256'd0, b[30:23] != 8'd0, b[22:0]} << (eb - emin);
    if (a[31] == b[31]) begin
      mag = ma + mb;
      sz  = a[31];
    end else if (ma >= mb) begin
      mag = ma - mb;
      sz  = a[31];
    end else begin
      mag = mb - ma;
      sz  = b[31];
    end
    if (mag == '0)
      return 32'd0;  // exact cancellation
    msb = 0;
    while ((mag >> msb) > 280'd1)
      msb++;
    e = emin + msb - 23;
    if (e < 1)
      e = 1;  // clamp into subnormal range
    s = e - emin;
    if (s > 0) begin
      rem      = mag >> (s - 1);  // half bit lands in rem[0]
      kept     = rem[25:1];
      low_mask = (280'd1 << (s - 1)) - 280'd1;
      if (rem[0] && (kept[0] || (mag & low_mask) != '0))
        kept = kept + 25'd1;
    end else begin
      kept = 25'(mag << (-s));
    end
    if (kept[24]) begin
      kept = kept >> 1;
      e    = e + 1;
    end
    if (e >= 255)
      return {sz, 8'hFF, 23'd0};
    return {sz, kept[23] ? 8'(e) : 8'd0, kept[22:0]};
  endfunction

  // ----------------------------
  // stimulus
  // ----------------------------
  function automatic fp32_t special_pick(input logic [2:0] sel);
    case (sel)
      3'd0:    return 32'h0000_0000;
      3'd1:    return 32'h8000_0000;
      3'd2:    return 32'h7F80_0000;
      3'd3:    return 32'hFF80_0000;
      3'd4:    return 32'h7FC0_0000;
      3'd5:    return 32'hFF81_2345;
      3'd6:    return 32'h0000_0001;  // smallest subnormal
      default: return 32'h7F7F_FFFF;
    endcase
  endfunction

  task automatic make_pair(output fp32_t a, output fp32_t b);
    logic [31:0] r;
    r = lcg_next();
    a = lcg_next();
    b = lcg_next();
    case (r[31:29])
      3'd3: b = special_pick(r[18:16]);
      3'd4: a = special_pick(r[21:19]);
      3'd5: b = {b[31], a[30:23] + {5'd0, r[10:8]}, b[22:0]};  // small exponent gap
      3'd6: b = {~a[31], a[30:3], b[2:0]};                     // near cancelling
      3'd7: begin
        a = {a[31], 8'd0, a[22:0]};
        b = {b[31], 7'd0, r[0], b[22:0]};
      end
      default: ;  // plain random bits
    endcase
  endtask

  task automatic reg_write(input reg_addr_t where, input logic [31:0] data);
    @(posedge clk);
    wr_en <= 1'b1;
    addr  <= where;
    wdata <= data;
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic reg_read(input reg_addr_t where, output logic [31:0] data);
    @(posedge clk);
    rd_en <= 1'b1;
    addr  <= where;
    @(posedge clk);
    rd_en <= 1'b0;
    @(negedge clk);
    data = rdata;  // registered one cycle after rd_en
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("Error %s expected %h actual %h", name, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic wait_done(output logic [31:0] status);
    status = '0;
    while (!status[STAT_DONE_BIT])
      reg_read(ADDR_STATUS, status);
  endtask

  task automatic run_add(input string name, input fp32_t a, input fp32_t b,
                         input fp32_t expected);
    logic [31:0] status;
    logic [31:0] z;
    reg_write(ADDR_OPA, a);
    reg_write(ADDR_OPB, b);
    reg_write(ADDR_CTRL, 32'd1);
    wait_done(status);
    check_value({name, " status"}, 32'd1 << STAT_DONE_BIT, status);
    reg_read(ADDR_RESULT, z);
    check_value(name, expected, z);
  endtask

  task automatic model_add(input string name, input fp32_t a, input fp32_t b);
    run_add(name, a, b, ref_sum(a, b));
  endtask

  // ----------------------------
  // test sequence
  // ----------------------------
  initial begin
    logic [31:0] rd;
    fp32_t       a, b, z, expected;
    int          n;
    seed  = 32'd32;
    rst   = 1'b1;
    wr_en = 1'b0;
    rd_en = 1'b0;
    addr  = '0;
    wdata = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    reg_read(ADDR_STATUS, rd);
    check_value("reset status", 32'd0, rd);
    reg_read(ADDR_RESULT, rd);
    check_value("reset result", 32'd0, rd);
    reg_read(ADDR_OPA, rd);
    check_value("reset opa", 32'd0, rd);
    reg_read(ADDR_OPB, rd);
    check_value("reset opb", 32'd0, rd);
    reg_write(ADDR_OPA, 32'h1234_5678);
    reg_write(ADDR_OPB, 32'hA5A5_0F0F);
    reg_read(ADDR_OPA, rd);
    check_value("opa readback", 32'h1234_5678, rd);
    reg_read(ADDR_OPB, rd);
    check_value("opb readback", 32'hA5A5_0F0F, rd);
    reg_read(ADDR_CTRL, rd);
    check_value("ctrl read", 32'd0, rd);

    for (n = 0; n < NUM_RANDOM; n++) begin
      make_pair(a, b);
      model_add($sformatf("random %0d", n), a, b);
    end

    // specials, results fixed by the format rules
    run_add("nan a", 32'h7FC0_0001, 32'h3F80_0000, 32'h7FC0_0000);
    run_add("nan b", 32'h3F80_0000, 32'hFF81_2345, 32'h7FC0_0000);
    run_add("inf plus finite", 32'h7F80_0000, 32'hC000_0000, 32'h7F80_0000);
    run_add("finite plus neg inf", 32'h4000_0000, 32'hFF80_0000, 32'hFF80_0000);
    run_add("inf minus inf", 32'h7F80_0000, 32'hFF80_0000, 32'h7FC0_0000);
    run_add("neg zeros", 32'h8000_0000, 32'h8000_0000, 32'h8000_0000);
    run_add("mixed zeros", 32'h0000_0000, 32'h8000_0000, 32'h0000_0000);
    run_add("exact cancel", 32'h3FC0_0000, 32'hBFC0_0000, 32'h0000_0000);
    run_add("overflow", 32'h7F7F_FFFF, 32'h7F7F_FFFF, 32'h7F80_0000);
    run_add("neg overflow", 32'hFF7F_FFFF, 32'hFF00_0000, 32'hFF80_0000);

    // subnormals and halfway rounding
    model_add("tiny subnormals", 32'h0000_0001, 32'h0000_0001);
    model_add("subnormal to normal", 32'h007F_FFFF, 32'h0000_0001);
    model_add("normal to subnormal", 32'h0080_0000, 32'h8000_0001);
    model_add("subnormal difference", 32'h00C0_0000, 32'h80BF_FFFF);
    model_add("tiny addend", 32'h3F80_0000, 32'h0040_0000);
    model_add("tie to even down", 32'h3F80_0000, 32'h3380_0000);
    model_add("tie to even up", 32'h3F80_0001, 32'h3380_0000);
    model_add("tie at max", 32'h7F7F_FFFF, 32'h7300_0000);
    model_add("below one", 32'h3F80_0000, 32'hB380_0001);

    // go while busy is dropped, operand rewrites leave the running sum alone
    expected = ref_sum(32'h3F80_0000, 32'h2F80_0001);
    reg_write(ADDR_OPA, 32'h3F80_0000);
    reg_write(ADDR_OPB, 32'h2F80_0001);
    reg_write(ADDR_CTRL, 32'd1);
    reg_write(ADDR_OPB, 32'h4120_0000);  // lands before the core takes b
    reg_write(ADDR_OPA, 32'hC2F6_0000);
    reg_write(ADDR_CTRL, 32'd1);
    wait_done(rd);
    reg_read(ADDR_RESULT, z);
    check_value("go while busy", expected, z);
    repeat (60) @(posedge clk);
    reg_read(ADDR_STATUS, rd);
    check_value("sticky done", 32'd1 << STAT_DONE_BIT, rd);
    reg_read(ADDR_RESULT, z);
    check_value("single result", expected, z);

    reg_write(ADDR_CTRL, 32'd1);  // next go clears done
    reg_read(ADDR_STATUS, rd);
    check_value("go clears done", 32'd1 << STAT_BUSY_BIT, rd);
    wait_done(rd);
    reg_read(ADDR_RESULT, z);
    check_value("second go", ref_sum(32'hC2F6_0000, 32'h4120_0000), z);

    $display("Test passed");
    $finish;
  end

  // watchdog, sized from the operation count
  initial begin
    repeat (NUM_OPS * 400) @(posedge clk);
    $display("Watchdog expired after %0d cycles, the unit never signalled done",
             NUM_OPS * 400);
    $display("Test failed");
    $fatal(1);
  end

endmodule

/* fp_add_unit.f */
source/fp_types_pkg.sv
source/fp_add_regs_pkg.sv
source/fp_stream_if.sv
source/fp_req_if.sv
source/fp_adder.sv
source/fp_add_driver.sv
source/fp_add_regs.sv
source/fp_add_unit.sv
verif/fp_add_unit_checker.sv
verif/fp_add_unit_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := fp_add_unit_tb
FILELIST  := fp_add_unit.f
BUILD     := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test passed

.PHONY: all compile run clean

all: run

compile: $(BUILD)/V$(TOP)

$(BUILD)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD) $(LOG)
